// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f verilog.f \
    --top-module reg_subsys_tb \
    -o reg_subsys_sim

./obj_dir/reg_subsys_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== test/reg_subsys_tb.sv ====
`default_nettype none

`include "reg_settings.svh"

module reg_subsys_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int REQ_CYCLES     = 2000;
    localparam int RAND_CYCLES    = 1900;
    localparam int TIMEOUT_CYCLES = REQ_CYCLES + 100;

    // Expected upstream response and the cycle it is due on
    typedef struct packed {
        logic [31:0]    due;
        reg_pkg::resp_t resp;
        logic [31:0]    data;
    } exp_t;

    logic                     clk;
    logic                     srst;
    logic                     wr;
    logic [`REG_ADDR_WID-1:0] wr_addr;
    logic [`REG_DATA_WID-1:0] wr_data;
    logic [`REG_STRB_WID-1:0] wr_strb;
    logic                     rd;
    logic [`REG_ADDR_WID-1:0] rd_addr;
    logic                     event_in;
    logic                     wr_ack;
    reg_pkg::resp_t           wr_resp;
    logic                     rd_ack;
    reg_pkg::resp_t           rd_resp;
    logic [`REG_DATA_WID-1:0] rd_data;

    integer      seed;
    logic [31:0] cyc;
    logic [31:0] wd_cnt = '0;
    logic [31:0] scratch_model [`REG_SCRATCH_WORDS];
    logic [31:0] cnt_model;
    logic        clr_pending;
    exp_t        wr_q [$];
    exp_t        rd_q [$];

    reg_subsys_top u_dut (
        .clk      ( clk ),
        .srst     ( srst ),
        .wr       ( wr ),
        .wr_addr  ( wr_addr ),
        .wr_data  ( wr_data ),
        .wr_strb  ( wr_strb ),
        .rd       ( rd ),
        .rd_addr  ( rd_addr ),
        .event_in ( event_in ),
        .wr_ack   ( wr_ack ),
        .wr_resp  ( wr_resp ),
        .rd_ack   ( rd_ack ),
        .rd_resp  ( rd_resp ),
        .rd_data  ( rd_data )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        wd_cnt <= wd_cnt + 32'd1;
        if (wd_cnt >= 32'(TIMEOUT_CYCLES)) begin
            $display("Timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "watchdog expired");
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL t=%0t: %s, got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_stray_ack(input string path);
        $display("A %s ack was not low at %0t while no response was due", path, $time);
        $display("Simulation FAILED");
        $fatal(1, "unexpected ack");
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic exp_t model_write(input logic [15:0] addr, input logic [31:0] data,
                                         input logic [3:0] strb);
        exp_t e;
        e.due  = cyc + 32'd3;
        e.data = '0;
        e.resp = reg_pkg::RESP_SLVERR;
        if (addr[15:8] == 8'h00) begin
            if (addr[7:0] < 8'h20) begin
                for (int b = 0; b < 4; b++) begin
                    if (strb[b]) begin
                        scratch_model[addr[4:2]][b*8 +: 8] = data[b*8 +: 8];
                    end
                end
                e.resp = reg_pkg::RESP_OKAY;
            end
        end else if (addr[15:8] == 8'h01) begin
            // Counter word clears while identifier and holes refuse
            if (addr[7:2] == 6'd1) begin
                clr_pending = 1'b1;
                e.resp      = reg_pkg::RESP_OKAY;
            end
        end else begin
            e.resp = reg_pkg::RESP_DECERR;
        end
        return e;
    endfunction

    function automatic exp_t model_read(input logic [15:0] addr);
        exp_t e;
        e.due  = cyc + 32'd3;
        e.data = `REG_BAD_ACCESS_DATA;
        e.resp = reg_pkg::RESP_SLVERR;
        if (addr[15:8] == 8'h00) begin
            if (addr[7:0] < 8'h20) begin
                e.data = scratch_model[addr[4:2]];
                e.resp = reg_pkg::RESP_OKAY;
            end
        end else if (addr[15:8] == 8'h01) begin
            if (addr[7:2] == 6'd0) begin
                e.data = `REG_BLOCK_ID;
                e.resp = reg_pkg::RESP_OKAY;
            end else if (addr[7:2] == 6'd1) begin
                e.data = cnt_model;
                e.resp = reg_pkg::RESP_OKAY;
            end
        end else begin
            e.resp = reg_pkg::RESP_DECERR;
        end
        return e;
    endfunction

    // Weighted pick over the address classes
    function automatic logic [15:0] gen_addr();
        logic [31:0] r;
        logic [3:0]  kind;
        logic [15:0] addr;
        kind = 4'($random(seed));
        r    = $random(seed);
        if (kind < 4'd6) begin
            addr = {8'h00, 3'b000, r[4:0]};
        end else if (kind < 4'd8) begin
            addr = {8'h00, 8'h20 + 8'(r % 32'd224)};
        end else if (kind == 4'd8) begin
            addr = 16'h0100;
        end else if (kind < 4'd11) begin
            addr = 16'h0104;
        end else if (kind == 4'd11) begin
            addr = 16'h0108 + 16'(r % 32'd248);
        end else begin
            addr = 16'h0200 + 16'(r % 32'd65024);
        end
        return addr;
    endfunction

    // ----------------------------------------
    // Cycle driver and response checks
    // ----------------------------------------
    task automatic check_acks();
        if (wr_q.size() > 0 && wr_q[0].due == cyc) begin
            check_value(32'(wr_ack), 32'd1, "write ack missing on its due cycle");
            check_value(32'(wr_resp), 32'(wr_q[0].resp), "write response");
            void'(wr_q.pop_front());
        end else begin
            if (wr_ack !== 1'b0) begin
                report_stray_ack("write");
            end
            check_value(32'(wr_resp), 32'(reg_pkg::RESP_SLVERR), "idle write response");
        end
        if (rd_q.size() > 0 && rd_q[0].due == cyc) begin
            check_value(32'(rd_ack), 32'd1, "read ack missing on its due cycle");
            check_value(32'(rd_resp), 32'(rd_q[0].resp), "read response");
            check_value(rd_data, rd_q[0].data, "read data");
            void'(rd_q.pop_front());
        end else begin
            if (rd_ack !== 1'b0) begin
                report_stray_ack("read");
            end
            check_value(32'(rd_resp), 32'(reg_pkg::RESP_SLVERR), "idle read response");
        end
    endtask

    task automatic do_cycle(input logic wr_en, input logic [15:0] waddr,
                            input logic [31:0] wdata, input logic [3:0] wstrb,
                            input logic rd_en, input logic [15:0] raddr, input logic ev);
        @(posedge clk);
        cyc = cyc + 32'd1;
        // Count after the next edge, which a read issued now returns
        if (clr_pending) begin
            cnt_model = '0;
        end else if (ev) begin
            cnt_model = cnt_model + 32'd1;
        end
        clr_pending = 1'b0;
        wr       <= wr_en;
        wr_addr  <= waddr;
        wr_data  <= wdata;
        wr_strb  <= wstrb;
        rd       <= rd_en;
        rd_addr  <= raddr;
        event_in <= ev;
        // Read first since it sees the bank before a same-cycle write
        if (rd_en) begin
            rd_q.push_back(model_read(raddr));
        end
        if (wr_en) begin
            wr_q.push_back(model_write(waddr, wdata, wstrb));
        end
        @(negedge clk);
        check_acks();
    endtask

    task automatic idle_cycle(input logic ev);
        do_cycle(1'b0, 16'h0000, 32'h0, 4'h0, 1'b0, 16'h0000, ev);
    endtask

    task automatic read_at(input logic [15:0] addr, input logic ev);
        do_cycle(1'b0, 16'h0000, 32'h0, 4'h0, 1'b1, addr, ev);
    endtask

    task automatic write_at(input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic ev);
        do_cycle(1'b1, addr, data, strb, 1'b0, 16'h0000, ev);
    endtask

    initial begin
        seed        = 37239;
        cyc         = '0;
        cnt_model   = '0;
        clr_pending = 1'b0;
        for (int i = 0; i < `REG_SCRATCH_WORDS; i++) begin
            scratch_model[i] = '0;
        end
        srst     = 1'b1;
        wr       = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        wr_strb  = '0;
        rd       = 1'b0;
        rd_addr  = '0;
        event_in = 1'b0;
        repeat (2) begin
            @(posedge clk);
            cyc = cyc + 32'd1;
        end
        srst <= 1'b0;

        // Quiet bus, then reset values
        repeat (8) idle_cycle(1'b0);
        for (int i = 0; i < `REG_SCRATCH_WORDS; i++) begin
            read_at(16'(i * 4), 1'b0);
        end
        read_at(16'h0104, 1'b0);

        // Identifier and counter in the status block
        read_at(16'h0100, 1'b0);
        write_at(16'h0100, 32'h1234_5678, 4'hF, 1'b0);
        repeat (4) read_at(16'h0104, 1'b1);
        write_at(16'h0104, 32'h0, 4'hF, 1'b1);
        read_at(16'h0104, 1'b1);
        read_at(16'h0104, 1'b0);
        read_at(16'h0104, 1'b0);

        // Error paths
        write_at(16'h0200, 32'hA5A5_A5A5, 4'hF, 1'b0);
        read_at(16'h0200, 1'b0);
        read_at(16'hFFFC, 1'b0);
        read_at(16'h0020, 1'b0);
        write_at(16'h00FC, 32'h0BAD_0BAD, 4'hF, 1'b0);
        read_at(16'h0108, 1'b0);
        write_at(16'h01F0, 32'h0BAD_0BAD, 4'hF, 1'b0);

        // Byte merge on one word
        write_at(16'h0008, 32'h1122_3344, 4'b0101, 1'b0);
        read_at(16'h0008, 1'b0);

        for (int n = 0; n < RAND_CYCLES; n++) begin
            do_cycle(($random(seed) & 3) != 0, gen_addr(), 32'($random(seed)),
                     4'($random(seed)), ($random(seed) & 3) != 0, gen_addr(),
                     1'($random(seed)));
        end

        while (wr_q.size() > 0 || rd_q.size() > 0) begin
            idle_cycle(1'b0);
        end
        repeat (4) idle_cycle(1'b0);

        $display("Simulation PASSED");
        $finish;
    end

endmodule : reg_subsys_tb

`default_nettype wire

// ==== verilog.f ====
+incdir+verilog
verilog/reg_pkg.sv
verilog/reg_decoder.sv
verilog/scratch_regs.sv
verilog/status_regs.sv
verilog/reg_resp_mux.sv
verilog/reg_subsys_top.sv
test/reg_subsys_tb.sv

// ==== verilog/reg_decoder.sv ====
`default_nettype none

`include "reg_settings.svh"

module reg_decoder (
    input  logic                     clk,
    input  logic                     srst,
    input  logic                     wr,
    input  logic                     rd,
    input  logic [`REG_ADDR_WID-1:0] wr_addr,
    input  logic [`REG_ADDR_WID-1:0] rd_addr,
    input  logic [`REG_DATA_WID-1:0] wr_data,
    input  logic [`REG_STRB_WID-1:0] wr_strb,
    output reg_pkg::client_req_t     scratch_req,
    output reg_pkg::client_req_t     status_req,
    output reg_pkg::dec_err_t        dec_err
);

    localparam logic [`REG_ADDR_WID-1:0] SCRATCH_BASE = `REG_SCRATCH_BASE;
    localparam logic [`REG_ADDR_WID-1:0] STATUS_BASE  = `REG_STATUS_BASE;

    reg_pkg::region_t wr_region;
    reg_pkg::region_t rd_region;

    // Upper address bits pick the region
    function automatic reg_pkg::region_t decode_region(input logic [`REG_ADDR_WID-1:0] addr);
        if (addr[`REG_ADDR_WID-1:8] == SCRATCH_BASE[`REG_ADDR_WID-1:8]) begin
            return reg_pkg::REGION_SCRATCH;
        end
        if (addr[`REG_ADDR_WID-1:8] == STATUS_BASE[`REG_ADDR_WID-1:8]) begin
            return reg_pkg::REGION_STATUS;
        end
        return reg_pkg::REGION_NONE;
    endfunction

    assign wr_region = decode_region(wr_addr);
    assign rd_region = decode_region(rd_addr);

    // ----------------------------------------
    // Request fanout
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            scratch_req.wr <= 1'b0;
            scratch_req.rd <= 1'b0;
            status_req.wr  <= 1'b0;
            status_req.rd  <= 1'b0;
            dec_err        <= '0;
        end else begin
            scratch_req.wr <= wr && (wr_region == reg_pkg::REGION_SCRATCH);
            scratch_req.rd <= rd && (rd_region == reg_pkg::REGION_SCRATCH);
            status_req.wr  <= wr && (wr_region == reg_pkg::REGION_STATUS);
            status_req.rd  <= rd && (rd_region == reg_pkg::REGION_STATUS);
            dec_err.wr_err <= wr && (wr_region == reg_pkg::REGION_NONE);
            dec_err.rd_err <= rd && (rd_region == reg_pkg::REGION_NONE);
        end
        // Payload is shared by both clients
        scratch_req.wr_offset <= wr_addr[7:0];
        scratch_req.rd_offset <= rd_addr[7:0];
        scratch_req.wdata     <= wr_data;
        scratch_req.wstrb     <= wr_strb;
        status_req.wr_offset  <= wr_addr[7:0];
        status_req.rd_offset  <= rd_addr[7:0];
        status_req.wdata      <= wr_data;
        status_req.wstrb      <= wr_strb;
    end

    // No access reaches a client and the error path at once
    a_wr_excl : assert property (@(posedge clk) disable iff (srst)
        !((scratch_req.wr || status_req.wr) && dec_err.wr_err));
    a_rd_excl : assert property (@(posedge clk) disable iff (srst)
        !((scratch_req.rd || status_req.rd) && dec_err.rd_err));

endmodule : reg_decoder

`default_nettype wire

// ==== verilog/reg_pkg.sv ====
`default_nettype none

`include "reg_settings.svh"

package reg_pkg;

    // ----------------------------------------
    // Enums
    // ----------------------------------------
    // AXI-style response encoding
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_t;

    typedef enum logic [1:0] {
        REGION_SCRATCH = 2'd0,
        REGION_STATUS  = 2'd1,
        REGION_NONE    = 2'd2
    } region_t;

    // ----------------------------------------
    // Structs
    // ----------------------------------------
    // Request to a single client, offsets are within the region
    typedef struct packed {
        logic                     wr;
        logic                     rd;
        logic [7:0]               wr_offset;
        logic [7:0]               rd_offset;
        logic [`REG_DATA_WID-1:0] wdata;
        logic [`REG_STRB_WID-1:0] wstrb;
    } client_req_t;

    typedef struct packed {
        logic                     wr_ack;
        resp_t                    wr_resp;
        logic                     rd_ack;
        resp_t                    rd_resp;
        logic [`REG_DATA_WID-1:0] rdata;
    } client_resp_t;

    // Registered decode-error pulses
    typedef struct packed {
        logic wr_err;
        logic rd_err;
    } dec_err_t;

endpackage : reg_pkg

`default_nettype wire

// ==== verilog/reg_resp_mux.sv ====
`default_nettype none

`include "reg_settings.svh"

module reg_resp_mux (
    input  logic                     clk,
    input  logic                     srst,
    input  reg_pkg::client_resp_t    scratch_resp,
    input  reg_pkg::client_resp_t    status_resp,
    input  reg_pkg::dec_err_t        dec_err,
    output logic                     wr_ack,
    output reg_pkg::resp_t           wr_resp,
    output logic                     rd_ack,
    output reg_pkg::resp_t           rd_resp,
    output logic [`REG_DATA_WID-1:0] rd_data
);

    // Decode errors lined up with the client stage
    reg_pkg::dec_err_t dec_err_d;

    always_ff @(posedge clk) begin
        if (srst) begin
            dec_err_d <= '0;
        end else begin
            dec_err_d <= dec_err;
        end
    end

    // ----------------------------------------
    // Write path
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ack  <= 1'b0;
            wr_resp <= reg_pkg::RESP_SLVERR;
        end else if (dec_err_d.wr_err) begin
            wr_ack  <= 1'b1;
            wr_resp <= reg_pkg::RESP_DECERR;
        end else if (scratch_resp.wr_ack) begin
            wr_ack  <= 1'b1;
            wr_resp <= scratch_resp.wr_resp;
        end else if (status_resp.wr_ack) begin
            wr_ack  <= 1'b1;
            wr_resp <= status_resp.wr_resp;
        end else begin
            wr_ack  <= 1'b0;
            wr_resp <= reg_pkg::RESP_SLVERR;
        end
    end

    // ----------------------------------------
    // Read path
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            rd_ack  <= 1'b0;
            rd_resp <= reg_pkg::RESP_SLVERR;
        end else if (dec_err_d.rd_err) begin
            rd_ack  <= 1'b1;
            rd_resp <= reg_pkg::RESP_DECERR;
        end else if (scratch_resp.rd_ack) begin
            rd_ack  <= 1'b1;
            rd_resp <= scratch_resp.rd_resp;
        end else if (status_resp.rd_ack) begin
            rd_ack  <= 1'b1;
            rd_resp <= status_resp.rd_resp;
        end else begin
            rd_ack  <= 1'b0;
            rd_resp <= reg_pkg::RESP_SLVERR;
        end
    end

    // Read data holds when nothing acks
    always_ff @(posedge clk) begin
        if (dec_err_d.rd_err) begin
            rd_data <= `REG_BAD_ACCESS_DATA;
        end else if (scratch_resp.rd_ack) begin
            rd_data <= scratch_resp.rdata;
        end else if (status_resp.rd_ack) begin
            rd_data <= status_resp.rdata;
        end
    end

    // One source per path per cycle, across decoder and clients
    a_wr_onehot : assert property (@(posedge clk) disable iff (srst)
        $onehot0({dec_err_d.wr_err, scratch_resp.wr_ack, status_resp.wr_ack}));
    a_rd_onehot : assert property (@(posedge clk) disable iff (srst)
        $onehot0({dec_err_d.rd_err, scratch_resp.rd_ack, status_resp.rd_ack}));

endmodule : reg_resp_mux

`default_nettype wire

// ==== verilog/reg_settings.svh ====
`ifndef REG_SETTINGS_SVH
`define REG_SETTINGS_SVH

// Bus widths
`define REG_ADDR_WID 16
`define REG_DATA_WID 32
`define REG_STRB_WID 4

// Address map, each region spans 0x100 bytes
`define REG_SCRATCH_BASE 16'h0000
`define REG_STATUS_BASE  16'h0100

// Scratch bank depth in 32-bit words
`define REG_SCRATCH_WORDS 8

// Fixed read values
`define REG_BLOCK_ID        32'h5EC0_0001
`define REG_BAD_ACCESS_DATA 32'hDEAD_BEEF

`endif

// ==== verilog/reg_subsys_top.sv ====
`default_nettype none

`include "reg_settings.svh"

module reg_subsys_top (
    input  logic                     clk,
    input  logic                     srst,
    input  logic                     wr,
    input  logic [`REG_ADDR_WID-1:0] wr_addr,
    input  logic [`REG_DATA_WID-1:0] wr_data,
    input  logic [`REG_STRB_WID-1:0] wr_strb,
    input  logic                     rd,
    input  logic [`REG_ADDR_WID-1:0] rd_addr,
    input  logic                     event_in,
    output logic                     wr_ack,
    output reg_pkg::resp_t           wr_resp,
    output logic                     rd_ack,
    output reg_pkg::resp_t           rd_resp,
    output logic [`REG_DATA_WID-1:0] rd_data
);

    reg_pkg::client_req_t  scratch_req;
    reg_pkg::client_req_t  status_req;
    reg_pkg::client_resp_t scratch_resp;
    reg_pkg::client_resp_t status_resp;
    reg_pkg::dec_err_t     dec_err;

    // ----------------------------------------
    // Decode and fanout
    // ----------------------------------------
    reg_decoder u_decoder (
        .clk         ( clk ),
        .srst        ( srst ),
        .wr          ( wr ),
        .rd          ( rd ),
        .wr_addr     ( wr_addr ),
        .rd_addr     ( rd_addr ),
        .wr_data     ( wr_data ),
        .wr_strb     ( wr_strb ),
        .scratch_req ( scratch_req ),
        .status_req  ( status_req ),
        .dec_err     ( dec_err )
    );

    // Clients
    scratch_regs u_scratch (
        .clk  ( clk ),
        .srst ( srst ),
        .req  ( scratch_req ),
        .resp ( scratch_resp )
    );

    status_regs u_status (
        .clk      ( clk ),
        .srst     ( srst ),
        .event_in ( event_in ),
        .req      ( status_req ),
        .resp     ( status_resp )
    );

    // ----------------------------------------
    // Response combine
    // ----------------------------------------
    reg_resp_mux u_resp_mux (
        .clk          ( clk ),
        .srst         ( srst ),
        .scratch_resp ( scratch_resp ),
        .status_resp  ( status_resp ),
        .dec_err      ( dec_err ),
        .wr_ack       ( wr_ack ),
        .wr_resp      ( wr_resp ),
        .rd_ack       ( rd_ack ),
        .rd_resp      ( rd_resp ),
        .rd_data      ( rd_data )
    );

endmodule : reg_subsys_top

`default_nettype wire

// ==== verilog/scratch_regs.sv ====
`default_nettype none

`include "reg_settings.svh"

module scratch_regs (
    input  logic                  clk,
    input  logic                  srst,
    input  reg_pkg::client_req_t  req,
    output reg_pkg::client_resp_t resp
);

    localparam int IDX_WID = $clog2(`REG_SCRATCH_WORDS);

    logic [`REG_DATA_WID-1:0] regs [`REG_SCRATCH_WORDS];

    logic               wr_hit;
    logic               rd_hit;
    logic [IDX_WID-1:0] wr_idx;
    logic [IDX_WID-1:0] rd_idx;

    // Word index, byte lane bits ignored
    assign wr_idx = req.wr_offset[IDX_WID+1:2];
    assign rd_idx = req.rd_offset[IDX_WID+1:2];
    assign wr_hit = req.wr_offset[7:2] < `REG_SCRATCH_WORDS;
    assign rd_hit = req.rd_offset[7:2] < `REG_SCRATCH_WORDS;

    // ----------------------------------------
    // Register bank
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            for (int i = 0; i < `REG_SCRATCH_WORDS; i++) begin
                regs[i] <= '0;
            end
        end else if (req.wr && wr_hit) begin
            for (int b = 0; b < `REG_STRB_WID; b++) begin
                if (req.wstrb[b]) begin
                    regs[wr_idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
                end
            end
        end
    end

    // ----------------------------------------
    // Responses
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            resp.wr_ack  <= 1'b0;
            resp.wr_resp <= reg_pkg::RESP_SLVERR;
            resp.rd_ack  <= 1'b0;
            resp.rd_resp <= reg_pkg::RESP_SLVERR;
        end else begin
            resp.wr_ack  <= req.wr;
            resp.wr_resp <= (req.wr && wr_hit) ? reg_pkg::RESP_OKAY : reg_pkg::RESP_SLVERR;
            resp.rd_ack  <= req.rd;
            resp.rd_resp <= (req.rd && rd_hit) ? reg_pkg::RESP_OKAY : reg_pkg::RESP_SLVERR;
        end
        // Reads see the bank before any write in the same cycle
        resp.rdata <= rd_hit ? regs[rd_idx] : `REG_BAD_ACCESS_DATA;
    end

endmodule : scratch_regs

`default_nettype wire

// ==== verilog/status_regs.sv ====
`default_nettype none

`include "reg_settings.svh"

module status_regs (
    input  logic                  clk,
    input  logic                  srst,
    input  logic                  event_in,
    input  reg_pkg::client_req_t  req,
    output reg_pkg::client_resp_t resp
);

    // Word offsets within the status region
    localparam logic [5:0] ID_WORD  = 6'h00;
    localparam logic [5:0] CNT_WORD = 6'h01;

    logic [`REG_DATA_WID-1:0] event_cnt;
    logic                     cnt_clr;

    assign cnt_clr = req.wr && (req.wr_offset[7:2] == CNT_WORD);

    // ----------------------------------------
    // Event counter
    // ----------------------------------------
    // Clear takes priority over a same-cycle event
    always_ff @(posedge clk) begin
        if (srst) begin
            event_cnt <= '0;
        end else if (cnt_clr) begin
            event_cnt <= '0;
        end else if (event_in) begin
            event_cnt <= event_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // Responses
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            resp.wr_ack  <= 1'b0;
            resp.wr_resp <= reg_pkg::RESP_SLVERR;
            resp.rd_ack  <= 1'b0;
            resp.rd_resp <= reg_pkg::RESP_SLVERR;
        end else begin
            resp.wr_ack  <= req.wr;
            resp.wr_resp <= cnt_clr ? reg_pkg::RESP_OKAY : reg_pkg::RESP_SLVERR;
            resp.rd_ack  <= req.rd;
            if (req.rd && (req.rd_offset[7:2] == ID_WORD || req.rd_offset[7:2] == CNT_WORD)) begin
                resp.rd_resp <= reg_pkg::RESP_OKAY;
            end else begin
                resp.rd_resp <= reg_pkg::RESP_SLVERR;
            end
        end
        case (req.rd_offset[7:2])
            ID_WORD:  resp.rdata <= `REG_BLOCK_ID;
            CNT_WORD: resp.rdata <= event_cnt;
            default:  resp.rdata <= `REG_BAD_ACCESS_DATA;
        endcase
    end

    // Counter steps by at most one unless a clear landed
    a_cnt_step : assert property (@(posedge clk) disable iff (srst)
        !$past(cnt_clr) |-> (event_cnt - $past(event_cnt)) <= 32'd1);

endmodule : status_regs

`default_nettype wire
